/* soc.f */
soc_pkg.sv
pi_if.sv
byte_addr.sv
dev_table.sv
pi_decoder.sv
ram_dev.sv
soc_top.sv
tb_soc_sva.sv
tb_soc.sv

/* run.sh */
#!/bin/sh
# Build and run the testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_soc -f soc.f -o tb_soc
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_soc +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q 'All tests passed!' sim.log; then
	exit 0
fi
exit 1

/* tb_soc.sv */
// Testbench for the peripheral subsystem with clock, reset and bus stimulus.
// Reference model of the table, RAM and resets, error count and watchdog.

`timescale 1ns/1ps
`default_nettype none

module tb_soc;

	localparam int          N_DEV    = 4;
	localparam int          N_WORDS  = 64;
	localparam int unsigned CACHE_SZ = 8;
	localparam int unsigned PRELDR   = 32'h0000_2000;
	localparam int unsigned CHIP_ID  = 32'h0000_00C5;
	localparam int          TBL_W    = soc_pkg::BLOCK_MAPSZ / 4;  // First table word.
	localparam int          RAM_W    = soc_pkg::RAM_BASE / 4;
	localparam int          N_ROUNDS = 3;
	localparam int          N_RAND   = 200;
	localparam int          N_OPS    = N_ROUNDS * 13 + 150 + N_RAND; // Upper bound on bus cycles.
	localparam int          LIMIT_NS = N_OPS * 20 * 2 + 1000;

	logic                        clk_i = 1'b0;
	logic                        rst_i;
	soc_pkg::op_e                op_i;
	logic [soc_pkg::WADDR_W-1:0] addr_i;
	logic [31:0]                 data_i;
	logic [3:0]                  sel_i;
	logic [31:0]                 data_o;
	logic [32*N_DEV-1:0]         dev_id_i;
	logic [32*N_DEV-1:0]         dev_mapsz_i;
	logic [N_DEV-1:0]            dev_useintr_i;
	logic                        rst0_o;
	logic                        rst1_o;
	logic                        rst2_o;

	logic [31:0] ram_ref [N_WORDS];
	logic [31:0] win_ref;
	logic        rst0_ref;
	logic        rst1_ref;
	logic        reload_ref;
	logic        pulse_ref;
	int          seed = 46691;
	int          errors = 0;
	logic        cur_valid = 1'b0;
	logic        chk_valid = 1'b0;
	logic [34:0] cur_exp;                        // Read data, then rst2, rst1, rst0.
	logic [34:0] chk_exp;
	string       cur_name;
	string       chk_name;

	always #10 clk_i = ~clk_i;

	soc_top #(
		.DEVMAPCNT    (N_DEV),
		.RAM_CACHE_SZ (CACHE_SZ),
		.PRELDR_ADDR  (PRELDR),
		.SOC_ID       (CHIP_ID),
		.RAM_WORDS    (N_WORDS)
	) u_dut (
		.clk_i         (clk_i),
		.rst_i         (rst_i),
		.op_i          (op_i),
		.addr_i        (addr_i),
		.data_i        (data_i),
		.sel_i         (sel_i),
		.data_o        (data_o),
		.dev_id_i      (dev_id_i),
		.dev_mapsz_i   (dev_mapsz_i),
		.dev_useintr_i (dev_useintr_i),
		.rst0_o        (rst0_o),
		.rst1_o        (rst1_o),
		.rst2_o        (rst2_o)
	);

	// Expected result of one operation; updates the model state.
	function automatic logic [31:0] model_op(input soc_pkg::op_e op, input logic [29:0] waddr,
			input logic [31:0] data, input logic [3:0] sel);
		logic [31:0] baddr;
		logic [31:0] msz;
		int          w;
		int          idx;
		model_op  = '0;
		pulse_ref = 1'b0;
		baddr = {waddr, sel[0] ? 2'd0 : sel[1] ? 2'd1 : sel[2] ? 2'd2 : sel[3] ? 2'd3 : 2'd0};
		w     = int'(waddr) - TBL_W;
		if (baddr >= soc_pkg::BLOCK_MAPSZ && baddr < soc_pkg::BLOCK_MAPSZ + win_ref) begin
			if (op == soc_pkg::OP_RD && w / 2 < N_DEV) begin
				msz = (w / 2 == 0) ? 32'd1024 : (w / 2 == 1) ? win_ref : dev_mapsz_i[w/2*32 +: 32];
				model_op = w[0] ? {msz[31:1], dev_useintr_i[w/2]} : dev_id_i[w/2*32 +: 32];
			end else if (op == soc_pkg::OP_RW && w == 0) begin
				case (data)
					0: model_op = soc_pkg::SOC_VERSION;
					1: model_op = CACHE_SZ;
					2: model_op = {30'd0, rst1_ref, rst0_ref};
					3: model_op = reload_ref ? 32'd0 : PRELDR;
					4: model_op = CHIP_ID;
					default: model_op = '0;
				endcase
			end else if (op == soc_pkg::OP_RW && w == 1) begin
				if (data <= 2) begin
					rst0_ref = (data != 1);          // Power-off and cold reset.
					rst1_ref = (data != 0);          // Warm and cold reset.
				end
				pulse_ref  = (data == 3);
				reload_ref = reload_ref || (data == 3);
			end
		end else if (baddr >= soc_pkg::RAM_BASE) begin
			idx = int'(waddr) % N_WORDS;
			if (op == soc_pkg::OP_RD || op == soc_pkg::OP_RW)
				model_op = ram_ref[idx];
			for (int b = 0; b < 4; b++) begin
				if ((op == soc_pkg::OP_WR || op == soc_pkg::OP_RW) && sel[b])
					ram_ref[idx][b*8 +: 8] = data[b*8 +: 8];
			end
		end
	endfunction

	task automatic issue(input soc_pkg::op_e op, input logic [29:0] waddr,
			input logic [31:0] data, input logic [3:0] sel, input string name);
		logic [31:0] rd_exp;
		@(posedge clk_i);
		#1;
		op_i      = op;
		addr_i    = waddr;
		data_i    = data;
		sel_i     = sel;
		rd_exp    = model_op(op, waddr, data, sel);
		cur_exp   = {rd_exp, pulse_ref, rst1_ref, rst0_ref};
		cur_name  = name;
		cur_valid = 1'b1;
	endtask

	task automatic apply_reset();
		@(posedge clk_i);
		#1;
		rst_i     = 1'b1;
		op_i      = soc_pkg::OP_NOP;
		cur_valid = 1'b0;
		repeat (2) @(posedge clk_i);
		#1;
		rst_i    = 1'b0;
		rst0_ref = 1'b0;
		rst1_ref = 1'b0;
	endtask

	// Random descriptors with the RAM ID at entry ram_pos, or nowhere for 4.
	task automatic load_table(input int ram_pos);
		logic [31:0] msz;
		win_ref = 32'd3072;
		for (int i = 0; i < N_DEV; i++) begin
			msz = ($random(seed) & 32'h1F) << 4;
			dev_mapsz_i[i*32 +: 32] = msz;
			dev_id_i[i*32 +: 32]    = (i == ram_pos) ? soc_pkg::DEV_ID_RAM
				: ($random(seed) & 32'hFFFF_FF00) | 32'(i + 2);
			dev_useintr_i[i]        = 1'($random(seed));
			if (i >= 2 && i < ram_pos)
				win_ref = win_ref - msz;
		end
	endtask

	always @(posedge clk_i) begin
		chk_valid <= cur_valid;
		chk_exp   <= cur_exp;
		chk_name  <= cur_name;
	end

	// Results of the last sampled operation are stable here.
	always @(negedge clk_i) begin
		if (chk_valid) begin
			assert ({data_o, rst2_o, rst1_o, rst0_o} === chk_exp) else begin
				$display("FAILED %s: expected %h, actual %h", chk_name, chk_exp,
					{data_o, rst2_o, rst1_o, rst0_o});
				errors++;
			end
		end
	end

	initial begin
		logic [29:0] wa;
		logic [31:0] d;
		int          rgn;
		int          pos0;
		rst_i         = 1'b1;
		op_i          = soc_pkg::OP_NOP;
		addr_i        = '0;
		data_i        = '0;
		sel_i         = '0;
		dev_id_i      = '0;
		dev_mapsz_i   = '0;
		dev_useintr_i = '0;
		win_ref       = 32'd3072;
		rst0_ref      = 1'b0;
		rst1_ref      = 1'b0;
		reload_ref    = 1'b0;
		pulse_ref     = 1'b0;
		repeat (2) @(posedge clk_i);
		#1;
		rst_i = 1'b0;

		for (int i = 0; i < N_WORDS; i++)
			issue(soc_pkg::OP_WR, 30'(RAM_W + i), 32'h5A5A_0000 ^ 32'((RAM_W + i) * 65539),
				4'hF, "ram_fill");
		pos0 = $unsigned($random(seed)) % 3;
		for (int r = 0; r < N_ROUNDS; r++) begin
			issue(soc_pkg::OP_NOP, '0, '0, '0, "idle");
			load_table(2 + (pos0 + r) % 3);         // Each round moves the RAM entry.
			for (int w = 0; w < 2 * N_DEV + 2; w++)
				issue(soc_pkg::OP_RD, 30'(TBL_W + w), '0, 4'hF, "descriptor");
			wa = 30'((soc_pkg::BLOCK_MAPSZ + win_ref) >> 2);
			issue(soc_pkg::OP_RD, wa - 1, '0, 4'h8, "window_last");
			issue(soc_pkg::OP_RD, wa, '0, 4'h1, "window_past");
		end

		for (int c = 0; c <= 5; c++)
			issue(soc_pkg::OP_RW, 30'(TBL_W), 32'(c), 4'hF, "info");
		for (int a = 0; a < 3; a++) begin
			issue(soc_pkg::OP_RW, 30'(TBL_W + 1), 32'(a), 4'hF, "action");
			issue(soc_pkg::OP_RW, 30'(TBL_W), soc_pkg::INFO_RSTSTAT, 4'hF, "info_rststat");
		end
		apply_reset();
		issue(soc_pkg::OP_RW, 30'(TBL_W), soc_pkg::INFO_RSTSTAT, 4'hF, "rststat_after_rst");
		issue(soc_pkg::OP_RW, 30'(TBL_W + 1), soc_pkg::ACT_RELOAD, 4'hF, "reload");
		issue(soc_pkg::OP_NOP, '0, '0, '0, "idle");
		issue(soc_pkg::OP_RW, 30'(TBL_W), soc_pkg::INFO_PRELDR, 4'hF, "preldr_after_reload");

		for (int k = 0; k < 8; k++) begin
			wa = 30'(RAM_W + ($unsigned($random(seed)) % 256));
			issue(soc_pkg::OP_WR, wa, $random(seed), 4'($random(seed)), "ram_partial_wr");
			issue(soc_pkg::OP_RD, wa, '0, 4'hF, "ram_merged");
			issue(soc_pkg::OP_RW, wa, $random(seed), 4'hF, "ram_swap");
			issue(soc_pkg::OP_RD, wa, '0, 4'hF, "ram_after_swap");
			issue(soc_pkg::OP_RD, 30'($unsigned($random(seed)) % TBL_W), '0, 4'hF, "unmapped");
		end

		for (int n = 0; n < N_RAND; n++) begin
			rgn = $unsigned($random(seed)) % 3;
			d   = $random(seed);
			wa  = (rgn == 0) ? 30'(TBL_W + ($unsigned($random(seed)) % 16))
				: (rgn == 1) ? 30'(RAM_W + ($unsigned($random(seed)) % 256))
				: 30'($unsigned($random(seed)) % TBL_W);
			if (rgn == 0)
				d = d & 32'h6;                       // Even codes never request a reload.
			issue(soc_pkg::op_e'(2'($random(seed))), wa, d, 4'($random(seed)), "random");
		end
		issue(soc_pkg::OP_NOP, '0, '0, '0, "idle");
		repeat (2) @(posedge clk_i);

		$display("Run complete: %0d check errors, %0d assertion errors", errors,
			u_dut.u_sva.fail_cnt);
		if (errors == 0 && u_dut.u_sva.fail_cnt == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

	initial begin
		#(LIMIT_NS);
		$display("Timeout: bus traffic did not finish within %0d ns", LIMIT_NS);
		$display("Test failures found");
		$finish;
	end

endmodule

`default_nettype wire

/* tb_soc_sva.sv */
// Concurrent checks on the reset outputs and the read data.
// Bound into soc_top.

`timescale 1ns/1ps
`default_nettype none

module soc_sva (
	input wire logic                       clk_i,
	input wire logic                       rst_i,
	input wire soc_pkg::op_e               op_i,
	input wire logic [soc_pkg::DATA_W-1:0] data_i,
	input wire logic                       rst0_i,
	input wire logic                       rst1_i,
	input wire logic                       rst2_i
);

	int unsigned fail_cnt = 0;                  // Failed assertions so far.

	reset_outputs_low: assert property (@(posedge clk_i)
		$fell(rst_i) |-> !rst0_i && !rst1_i && !rst2_i)
	else begin
		$error("reset outputs high in the first cycle after reset");
		fail_cnt++;
	end

	// Reload request gives a single-cycle pulse.
	reload_pulse_short: assert property (@(posedge clk_i) disable iff (rst_i)
		rst2_i |=> !rst2_i)
	else begin
		$error("rst2_o high for two cycles in a row");
		fail_cnt++;
	end

	nop_reads_zero: assert property (@(posedge clk_i) disable iff (rst_i)
		op_i == soc_pkg::OP_NOP |=> data_i == '0)
	else begin
		$error("data_o not zero after a NOP");
		fail_cnt++;
	end

endmodule

bind soc_top soc_sva u_sva (
	.clk_i  (clk_i),
	.rst_i  (rst_i),
	.op_i   (op_i),
	.data_i (data_o),
	.rst0_i (rst0_o),
	.rst1_i (rst1_o),
	.rst2_i (rst2_o)
);

`default_nettype wire

/* soc_top.sv */
// Peripheral subsystem top level with plain ports.
// Decoder, device table and RAM device.

`timescale 1ns/1ps
`default_nettype none

module soc_top #(
	parameter int          DEVMAPCNT    = 4,
	parameter int unsigned RAM_CACHE_SZ = 2,
	parameter int unsigned PRELDR_ADDR  = 32'h0000_1000,
	parameter int unsigned SOC_ID       = 32'h0000_0007,
	parameter int          RAM_WORDS    = 64
) (
	input  wire logic                                    clk_i,
	input  wire logic                                    rst_i,
	input  wire soc_pkg::op_e                            op_i,
	input  wire logic [soc_pkg::WADDR_W-1:0]             addr_i,
	input  wire logic [soc_pkg::DATA_W-1:0]              data_i,
	input  wire logic [soc_pkg::SEL_W-1:0]               sel_i,
	output logic      [soc_pkg::DATA_W-1:0]              data_o,
	input  wire logic [soc_pkg::DATA_W*DEVMAPCNT-1:0]    dev_id_i,
	input  wire logic [soc_pkg::DATA_W*DEVMAPCNT-1:0]    dev_mapsz_i,
	input  wire logic [DEVMAPCNT-1:0]                    dev_useintr_i,
	output logic                                         rst0_o,
	output logic                                         rst1_o,
	output logic                                         rst2_o
);

	logic [soc_pkg::DATA_W-1:0] tbl_size;  // Table window size.

	pi_if tbl_bus ();
	pi_if ram_bus ();

	pi_decoder u_decoder (
		.clk_i      (clk_i),
		.rst_i      (rst_i),
		.op_i       (op_i),
		.addr_i     (addr_i),
		.data_i     (data_i),
		.sel_i      (sel_i),
		.data_o     (data_o),
		.tbl_size_i (tbl_size),
		.tbl_m      (tbl_bus.master),
		.ram_m      (ram_bus.master)
	);

	dev_table #(
		.DEVMAPCNT    (DEVMAPCNT),
		.RAM_CACHE_SZ (RAM_CACHE_SZ),
		.PRELDR_ADDR  (PRELDR_ADDR),
		.SOC_ID       (SOC_ID)
	) u_dev_table (
		.clk_i         (clk_i),
		.rst_i         (rst_i),
		.bus           (tbl_bus.slave),
		.dev_id_i      (dev_id_i),
		.dev_mapsz_i   (dev_mapsz_i),
		.dev_useintr_i (dev_useintr_i),
		.mapsz_o       (tbl_size),
		.rst0_o        (rst0_o),
		.rst1_o        (rst1_o),
		.rst2_o        (rst2_o)
	);

	ram_dev #(
		.RAM_WORDS (RAM_WORDS)
	) u_ram (
		.clk_i (clk_i),
		.bus   (ram_bus.slave)
	);

endmodule

`default_nettype wire

/* ram_dev.sv */
// Byte-writable RAM device on the peripheral bus.
// One cycle of read latency; swap returns the old word.

`timescale 1ns/1ps
`default_nettype none

module ram_dev #(
	parameter int RAM_WORDS = 64
) (
	input  wire logic clk_i,
	pi_if.slave       bus
);

	localparam int DW    = soc_pkg::DATA_W;
	localparam int IDX_W = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1;

	logic [DW-1:0]               mem [RAM_WORDS];
	logic [soc_pkg::WADDR_W-1:0] word;
	logic [IDX_W-1:0]            widx;
	logic                        do_wr;
	logic                        do_rd;

	assign word  = bus.baddr[soc_pkg::BADDR_W-1:2];
	assign widx  = IDX_W'(word % RAM_WORDS);     // Address wraps.
	assign do_wr = (bus.op == soc_pkg::OP_WR) || (bus.op == soc_pkg::OP_RW);
	assign do_rd = (bus.op == soc_pkg::OP_RD) || (bus.op == soc_pkg::OP_RW);

	// Read sees the old word, so a swap returns it.
	always_ff @(posedge clk_i) begin
		if (do_rd)
			bus.rdata <= mem[widx];
	end

	always_ff @(posedge clk_i) begin
		if (do_wr) begin
			for (int b = 0; b < soc_pkg::SEL_W; b++) begin
				if (bus.sel[b])
					mem[widx][b*8 +: 8] <= bus.wdata[b*8 +: 8]; // Selected lanes only.
			end
		end
	end

endmodule

`default_nettype wire

/* pi_decoder.sv */
// Address decoder for the device table and the RAM.
// Routes requests forward, muxes registered read data back.

`timescale 1ns/1ps
`default_nettype none

module pi_decoder (
	input  wire logic                          clk_i,
	input  wire logic                          rst_i,
	input  wire soc_pkg::op_e                  op_i,
	input  wire logic [soc_pkg::WADDR_W-1:0]   addr_i,
	input  wire logic [soc_pkg::DATA_W-1:0]    data_i,
	input  wire logic [soc_pkg::SEL_W-1:0]     sel_i,
	output logic      [soc_pkg::DATA_W-1:0]    data_o,
	input  wire logic [soc_pkg::DATA_W-1:0]    tbl_size_i,
	pi_if.master                               tbl_m,
	pi_if.master                               ram_m
);

	typedef enum logic [1:0] {
		TGT_NONE,
		TGT_TBL,
		TGT_RAM
	} tgt_e;

	logic [soc_pkg::BADDR_W-1:0] baddr;
	logic [soc_pkg::BADDR_W-1:0] tbl_end;
	logic                        hit_tbl;
	logic                        hit_ram;
	tgt_e                        tgt_d;
	tgt_e                        tgt_q;

	byte_addr u_byte_addr (
		.waddr_i (addr_i),
		.sel_i   (sel_i),
		.baddr_o (baddr)
	);

	assign tbl_end = soc_pkg::BLOCK_MAPSZ + tbl_size_i;
	assign hit_tbl = (baddr >= soc_pkg::BLOCK_MAPSZ) && (baddr < tbl_end);
	assign hit_ram = !hit_tbl && (baddr >= soc_pkg::RAM_BASE);

	always_comb begin
		if (hit_tbl)
			tgt_d = TGT_TBL;
		else if (hit_ram)
			tgt_d = TGT_RAM;
		else
			tgt_d = TGT_NONE;                        // Unmapped.
	end

	// Unselected targets see a NOP.
	assign tbl_m.op    = hit_tbl ? op_i : soc_pkg::OP_NOP;
	assign tbl_m.baddr = baddr - soc_pkg::BLOCK_MAPSZ;
	assign tbl_m.wdata = data_i;
	assign tbl_m.sel   = sel_i;

	assign ram_m.op    = hit_ram ? op_i : soc_pkg::OP_NOP;
	assign ram_m.baddr = baddr - soc_pkg::RAM_BASE;
	assign ram_m.wdata = data_i;
	assign ram_m.sel   = sel_i;

	// Only reads and swaps return data; everything else reads zero.
	always_ff @(posedge clk_i) begin
		if (rst_i)
			tgt_q <= TGT_NONE;
		else if (op_i == soc_pkg::OP_RD || op_i == soc_pkg::OP_RW)
			tgt_q <= tgt_d;
		else
			tgt_q <= TGT_NONE;
	end

	always_comb begin
		case (tgt_q)
			TGT_TBL: data_o = tbl_m.rdata;
			TGT_RAM: data_o = ram_m.rdata;
			default: data_o = '0;
		endcase
	end

endmodule

`default_nettype wire

/* dev_table.sv */
// Device table with descriptor reads and window sizing.
// INFO queries and ACTION reset control at words 0 and 1.

`timescale 1ns/1ps
`default_nettype none

module dev_table #(
	parameter int          DEVMAPCNT    = 4,
	parameter int unsigned RAM_CACHE_SZ = 2,
	parameter int unsigned PRELDR_ADDR  = 0,
	parameter int unsigned SOC_ID       = 0
) (
	input  wire logic                                    clk_i,
	input  wire logic                                    rst_i,
	pi_if.slave                                          bus,
	input  wire logic [soc_pkg::DATA_W*DEVMAPCNT-1:0]    dev_id_i,
	input  wire logic [soc_pkg::DATA_W*DEVMAPCNT-1:0]    dev_mapsz_i,
	input  wire logic [DEVMAPCNT-1:0]                    dev_useintr_i,
	output logic      [soc_pkg::DATA_W-1:0]              mapsz_o,
	output logic                                         rst0_o,
	output logic                                         rst1_o,
	output logic                                         rst2_o
);

	localparam int DW    = soc_pkg::DATA_W;
	localparam int IDX_W = $clog2(DEVMAPCNT);

	logic [DW-1:0]               dev_id    [DEVMAPCNT];
	logic [DW-1:0]               dev_mapsz [DEVMAPCNT];
	logic [DW-1:0]               win_size;
	logic                        ram_seen;
	logic [soc_pkg::WADDR_W-1:0] word;
	logic [soc_pkg::WADDR_W-2:0] entry;
	logic                        entry_ok;
	logic [IDX_W-1:0]            idx;
	logic [DW-1:0]               msz;
	logic [DW-1:0]               rd_word;
	logic [DW-1:0]               info_word;
	logic                        act_req;
	logic                        reload_q = 1'b0; // Reload requested since power-up.

	always_comb begin
		for (int i = 0; i < DEVMAPCNT; i++) begin
			dev_id[i]    = dev_id_i[i*DW +: DW];
			dev_mapsz[i] = dev_mapsz_i[i*DW +: DW];
		end
	end

	// Window shrinks until the first RAM entry lands on RAM_BASE.
	always_comb begin
		win_size = DW'(soc_pkg::RAM_BASE - soc_pkg::BLOCK_MAPSZ);
		ram_seen = 1'b0;
		for (int i = 2; i < DEVMAPCNT; i++) begin
			if (dev_id[i] == soc_pkg::DEV_ID_RAM)
				ram_seen = 1'b1;
			if (!ram_seen)
				win_size = win_size - dev_mapsz[i];
		end
	end

	assign word     = bus.baddr[soc_pkg::BADDR_W-1:2];
	assign entry    = word[soc_pkg::WADDR_W-1:1];    // Two words per entry.
	assign entry_ok = (entry < DEVMAPCNT);
	assign idx      = entry[IDX_W-1:0];

	always_comb begin
		if (idx == 0)
			msz = DW'(soc_pkg::BLOCK_MAPSZ);
		else if (idx == 1)
			msz = mapsz_o;                           // Own window.
		else
			msz = dev_mapsz[idx];
	end

	always_comb begin
		rd_word = '0;
		if (entry_ok) begin
			if (!word[0])
				rd_word = dev_id[idx];
			else
				rd_word = {msz[DW-1:1], dev_useintr_i[idx]};
		end
	end

	always_comb begin
		case (bus.wdata)
			soc_pkg::INFO_VERSION: info_word = soc_pkg::SOC_VERSION;
			soc_pkg::INFO_CACHESZ: info_word = DW'(RAM_CACHE_SZ);
			soc_pkg::INFO_RSTSTAT: info_word = {{(DW-2){1'b0}}, rst1_o, rst0_o};
			soc_pkg::INFO_PRELDR:  info_word = reload_q ? '0 : DW'(PRELDR_ADDR);
			soc_pkg::INFO_SOCID:   info_word = DW'(SOC_ID);
			default:               info_word = '0;
		endcase
	end

	assign act_req = (bus.op == soc_pkg::OP_RW) && (word == 1);

	// Read data and window size.
	always_ff @(posedge clk_i) begin
		mapsz_o <= win_size;
		if (bus.op == soc_pkg::OP_RD)
			bus.rdata <= rd_word;
		else if (bus.op == soc_pkg::OP_RW)
			bus.rdata <= (word == 0) ? info_word : '0; // ACTION answers zero.
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			rst0_o <= 1'b0;
			rst1_o <= 1'b0;
			rst2_o <= 1'b0;
		end else begin
			rst2_o <= act_req && (bus.wdata == soc_pkg::ACT_RELOAD); // One-cycle pulse.
			if (act_req) begin
				case (bus.wdata)
					soc_pkg::ACT_PWROFF: begin
						rst0_o <= 1'b1;
						rst1_o <= 1'b0;
					end
					soc_pkg::ACT_WRESET: begin
						rst0_o <= 1'b0;
						rst1_o <= 1'b1;
					end
					soc_pkg::ACT_CRESET: begin
						rst0_o <= 1'b1;
						rst1_o <= 1'b1;
					end
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (act_req && bus.wdata == soc_pkg::ACT_RELOAD)
			reload_q <= 1'b1;                        // Hides the pre-loader address.
	end

endmodule

`default_nettype wire

/* byte_addr.sv */
// Word address plus byte selects to byte address.
// Low bits come from the lowest set byte select.

`timescale 1ns/1ps
`default_nettype none

module byte_addr (
	input  wire logic [soc_pkg::WADDR_W-1:0] waddr_i,
	input  wire logic [soc_pkg::SEL_W-1:0]   sel_i,
	output logic      [soc_pkg::BADDR_W-1:0] baddr_o
);

	localparam int LSB_W = $clog2(soc_pkg::SEL_W);

	logic [LSB_W-1:0] lsb;

	// Scan from the top so the lowest set select wins.
	always_comb begin
		lsb = '0;
		for (int i = soc_pkg::SEL_W - 1; i >= 0; i--) begin
			if (sel_i[i])
				lsb = LSB_W'(i);
		end
	end

	assign baddr_o = {waddr_i, lsb};

endmodule

`default_nettype wire

/* pi_if.sv */
// Peripheral bus between the address decoder and its targets.
// No handshake; targets answer one cycle after the request.

`timescale 1ns/1ps
`default_nettype none

interface pi_if;

	soc_pkg::op_e                   op;     // Operation.
	logic [soc_pkg::BADDR_W-1:0]    baddr;  // Target-relative byte address.
	logic [soc_pkg::DATA_W-1:0]     wdata;
	logic [soc_pkg::SEL_W-1:0]      sel;
	logic [soc_pkg::DATA_W-1:0]     rdata;  // Registered by the target.

	modport master (
		output op,
		output baddr,
		output wdata,
		output sel,
		input  rdata
	);

	modport slave (
		input  op,
		input  baddr,
		input  wdata,
		input  sel,
		output rdata
	);

endinterface

`default_nettype wire

/* soc_pkg.sv */
// Shared bus widths, operation codes and device IDs.
// Region bases, version word, INFO and ACTION codes.

`default_nettype none

package soc_pkg;

	localparam int DATA_W  = 32;                          // Bus and table word.
	localparam int WADDR_W = 30;                          // Word address.
	localparam int SEL_W   = 4;                           // Byte selects.
	localparam int BADDR_W = WADDR_W + $clog2(SEL_W);     // Byte address.

	typedef enum logic [1:0] {
		OP_NOP = 2'b00,
		OP_WR  = 2'b01,
		OP_RD  = 2'b10,
		OP_RW  = 2'b11
	} op_e;

	localparam logic [DATA_W-1:0] DEV_ID_RAM = 1;         // Marks a RAM entry.

	// Entry 0 is the block device; the table window follows it.
	localparam logic [BADDR_W-1:0] BLOCK_MAPSZ = 1024;
	localparam logic [BADDR_W-1:0] RAM_BASE    = 4096;    // First RAM device.

	localparam logic [DATA_W-1:0] SOC_VERSION = 32'h0001_0200;

	// INFO query codes, passed as write data at word 0.
	localparam logic [DATA_W-1:0] INFO_VERSION = 0;
	localparam logic [DATA_W-1:0] INFO_CACHESZ = 1;
	localparam logic [DATA_W-1:0] INFO_RSTSTAT = 2;
	localparam logic [DATA_W-1:0] INFO_PRELDR  = 3;
	localparam logic [DATA_W-1:0] INFO_SOCID   = 4;

	// ACTION codes, passed as write data at word 1.
	localparam logic [DATA_W-1:0] ACT_PWROFF = 0;
	localparam logic [DATA_W-1:0] ACT_WRESET = 1;
	localparam logic [DATA_W-1:0] ACT_CRESET = 2;
	localparam logic [DATA_W-1:0] ACT_RELOAD = 3;

endpackage

`default_nettype wire
